// File: event_queue.sv
`timescale 1ns/100ps
`default_nettype none

module event_queue #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push_valid,
    output logic     push_ready,
    input  payload_t push_data,
    output logic     pop_valid,
    input  logic     pop_ready,
    output payload_t pop_data,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W:0] COUNT_FULL = (PTR_W + 1)'(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign push_ready = (count != COUNT_FULL);
    assign pop_valid  = (count != '0);
    assign empty      = (count == '0);
    assign pop_data   = mem[rd_ptr];

    assign do_push = push_valid && push_ready;
    assign do_pop  = pop_valid && pop_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave occupancy unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

// File: kbd_lcd_assert.sv
`timescale 1ns/100ps
`default_nettype none

module kbd_lcd_assert (
    input logic       clk,
    input logic       rst,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic [3:0] column,
    input logic       lcd_csx,
    input logic       lcd_wrx,
    input logic       lcd_dcx,
    input logic [7:0] lcd_data
);

    // Slave ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack stayed high for more than one cycle");

    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack outside an active bus cycle");

    // Write strobe only inside chip select
    wrx_inside_csx: assert property (@(posedge clk) disable iff (rst) !lcd_wrx |-> !lcd_csx)
        else $error("lcd_wrx low while lcd_csx high");

    // Bus value frozen from setup through hold
    bus_stable: assert property (@(posedge clk) disable iff (rst)
        !lcd_csx |=> (lcd_csx || $stable({lcd_dcx, lcd_data})))
        else $error("lcd_dcx or lcd_data changed while lcd_csx low");

    column_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(column))
        else $error("column drive is not one-hot");

endmodule

bind kbd_lcd_top kbd_lcd_assert kbd_lcd_assert_i (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .column   (column),
    .lcd_csx  (lcd_csx),
    .lcd_wrx  (lcd_wrx),
    .lcd_dcx  (lcd_dcx),
    .lcd_data (lcd_data)
);

`default_nettype wire

// File: kbd_lcd_params.svh
`ifndef KBD_LCD_PARAMS_SVH
`define KBD_LCD_PARAMS_SVH

`default_nettype none

// Keypad scan timing
`define KL_SCAN_DWELL 16
`define KL_DEBOUNCE_SWEEPS 2

// Queue depths
`define KL_KEY_DEPTH 4
`define KL_LCD_DEPTH 4

// Cycles with the LCD write strobe low
`define KL_WR_LOW 2

// Register word indices, taken from wb_adr[3:2]
`define KL_REG_KEY 0
`define KL_REG_STATUS 1
`define KL_REG_LCD_CMD 2
`define KL_REG_LCD_DATA 3

`default_nettype wire

`endif

// File: kbd_lcd_pkg.sv
`default_nettype none

package kbd_lcd_pkg;

    // Key number, column index times four plus row index
    typedef logic [3:0] key_code_t;

    // One byte for the LCD bus
    // is_data high selects data, low selects command
    typedef struct packed {
        logic       is_data;
        logic [7:0] value;
    } lcd_byte_t;

    // Word index of a register
    typedef logic [1:0] reg_index_t;

endpackage

`default_nettype wire

// File: kbd_lcd_top.sv
`timescale 1ns/100ps
`include "kbd_lcd_params.svh"
`default_nettype none

module kbd_lcd_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    input  logic [3:0]  row,
    output logic [3:0]  column,
    output logic        lcd_csx,
    output logic        lcd_wrx,
    output logic        lcd_dcx,
    output logic [7:0]  lcd_data
);

    logic                   scan_pulse;
    logic [1:0]             column_index;
    logic                   event_valid;
    kbd_lcd_pkg::key_code_t event_code;
    logic                   key_valid;
    kbd_lcd_pkg::key_code_t key_code;
    logic                   key_pop;
    logic                   lcd_push_valid;
    logic                   lcd_push_ready;
    kbd_lcd_pkg::lcd_byte_t lcd_push_data;
    logic                   lcd_empty;
    logic                   lcd_byte_valid;
    logic                   lcd_byte_ready;
    kbd_lcd_pkg::lcd_byte_t lcd_byte_data;
    logic                   lcd_idle;

    scan_timer scan_timer_i (
        .clk          (clk),
        .rst          (rst),
        .column       (column),
        .scan_pulse   (scan_pulse),
        .column_index (column_index)
    );

    keypad_decoder keypad_decoder_i (
        .clk          (clk),
        .rst          (rst),
        .row          (row),
        .column_index (column_index),
        .scan_pulse   (scan_pulse),
        .event_valid  (event_valid),
        .event_code   (event_code)
    );

    // Keypad cannot stall, a press is dropped when this queue is full
    event_queue #(
        .payload_t (kbd_lcd_pkg::key_code_t),
        .DEPTH     (`KL_KEY_DEPTH)
    ) key_queue_i (
        .clk        (clk),
        .rst        (rst),
        .push_valid (event_valid),
        .push_ready (),
        .push_data  (event_code),
        .pop_valid  (key_valid),
        .pop_ready  (key_pop),
        .pop_data   (key_code),
        .empty      ()
    );

    event_queue #(
        .payload_t (kbd_lcd_pkg::lcd_byte_t),
        .DEPTH     (`KL_LCD_DEPTH)
    ) lcd_queue_i (
        .clk        (clk),
        .rst        (rst),
        .push_valid (lcd_push_valid),
        .push_ready (lcd_push_ready),
        .push_data  (lcd_push_data),
        .pop_valid  (lcd_byte_valid),
        .pop_ready  (lcd_byte_ready),
        .pop_data   (lcd_byte_data),
        .empty      (lcd_empty)
    );

    lcd_write_fsm lcd_write_fsm_i (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (lcd_byte_valid),
        .byte_ready (lcd_byte_ready),
        .byte_data  (lcd_byte_data),
        .idle       (lcd_idle),
        .lcd_csx    (lcd_csx),
        .lcd_wrx    (lcd_wrx),
        .lcd_dcx    (lcd_dcx),
        .lcd_data   (lcd_data)
    );

    mmio_regs mmio_regs_i (
        .clk            (clk),
        .rst            (rst),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .key_valid      (key_valid),
        .key_code       (key_code),
        .key_pop        (key_pop),
        .lcd_push_valid (lcd_push_valid),
        .lcd_push_ready (lcd_push_ready),
        .lcd_push_data  (lcd_push_data),
        .lcd_idle       (lcd_idle),
        .lcd_empty      (lcd_empty)
    );

endmodule

`default_nettype wire

// File: keypad_decoder.sv
`timescale 1ns/100ps
`include "kbd_lcd_params.svh"
`default_nettype none

module keypad_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [3:0]            row,
    input  logic [1:0]            column_index,
    input  logic                  scan_pulse,
    output logic                  event_valid,
    output kbd_lcd_pkg::key_code_t event_code
);

    localparam int STAB_W = $clog2(`KL_DEBOUNCE_SWEEPS + 1);
    localparam logic [STAB_W-1:0] STAB_MAX = STAB_W'(`KL_DEBOUNCE_SWEEPS);

    logic                   cand_hit;
    kbd_lcd_pkg::key_code_t cand_code;
    logic                   prev_hit;
    kbd_lcd_pkg::key_code_t prev_code;
    logic [STAB_W-1:0]      stable_cnt;
    logic [STAB_W-1:0]      stable_next;
    logic                   armed;

    logic                   row_hit;
    logic [1:0]             low_row;
    kbd_lcd_pkg::key_code_t sample_code;
    logic                   sweep_end;
    logic                   final_hit;
    kbd_lcd_pkg::key_code_t final_code;
    logic                   emit;

    always_comb begin
        row_hit = |row;
        // Lowest pressed row wins
        low_row = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (row[i]) begin
                low_row = 2'(i);
            end
        end
        sample_code = kbd_lcd_pkg::key_code_t'({column_index, low_row});
        sweep_end   = scan_pulse && (column_index == 2'd3);

        // Columns are scanned in order, so the first hit has the lowest key number
        final_hit  = cand_hit || row_hit;
        final_code = cand_hit ? cand_code : sample_code;

        if (!final_hit) begin
            stable_next = '0;
        end else if (prev_hit && (final_code == prev_code)) begin
            stable_next = (stable_cnt == STAB_MAX) ? stable_cnt : stable_cnt + 1'b1;
        end else begin
            stable_next = STAB_W'(1);
        end

        emit = sweep_end && armed && (stable_next == STAB_MAX);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cand_hit    <= 1'b0;
            prev_hit    <= 1'b0;
            stable_cnt  <= '0;
            armed       <= 1'b1;
            event_valid <= 1'b0;
        end else begin
            event_valid <= emit;
            if (sweep_end) begin
                cand_hit   <= 1'b0;
                prev_hit   <= final_hit;
                stable_cnt <= stable_next;
                if (emit) begin
                    armed <= 1'b0;
                end else if (!final_hit) begin
                    // Empty sweep means the key was released
                    armed <= 1'b1;
                end
            end else if (scan_pulse && row_hit) begin
                cand_hit <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scan_pulse && !cand_hit) begin
            cand_code <= sample_code;
        end
        if (sweep_end) begin
            prev_code <= final_code;
        end
        if (emit) begin
            event_code <= final_code;
        end
    end

endmodule

`default_nettype wire

// File: lcd_write_fsm.sv
`timescale 1ns/100ps
`include "kbd_lcd_params.svh"
`default_nettype none

module lcd_write_fsm (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   byte_valid,
    output logic                   byte_ready,
    input  kbd_lcd_pkg::lcd_byte_t byte_data,
    output logic                   idle,
    output logic                   lcd_csx,
    output logic                   lcd_wrx,
    output logic                   lcd_dcx,
    output logic [7:0]             lcd_data
);

    localparam int CNT_W = ($clog2(`KL_WR_LOW) > 0) ? $clog2(`KL_WR_LOW) : 1;
    localparam logic [CNT_W-1:0] STROBE_LAST = CNT_W'(`KL_WR_LOW - 1);

    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        STROBE,
        HOLD,
        GAP
    } state_t;

    state_t           state;
    state_t           state_next;
    logic [CNT_W-1:0] strobe_cnt;

    // New bytes only taken while the bus is released
    assign byte_ready = (state == IDLE);
    assign idle       = (state == IDLE);

    // Chip select spans setup through hold, strobe only in STROBE
    assign lcd_csx = !((state == SETUP) || (state == STROBE) || (state == HOLD));
    assign lcd_wrx = (state != STROBE);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (byte_valid) begin
                    state_next = SETUP;
                end
            end
            SETUP:   state_next = STROBE;
            STROBE: begin
                if (strobe_cnt == STROBE_LAST) begin
                    state_next = HOLD;
                end
            end
            HOLD:    state_next = GAP;
            GAP:     state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            strobe_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == STROBE) begin
                strobe_cnt <= strobe_cnt + 1'b1;
            end else begin
                strobe_cnt <= '0;
            end
        end
    end

    // Bus value latched on accept and held until the next byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lcd_dcx  <= 1'b0;
            lcd_data <= 8'h00;
        end else if (byte_valid && byte_ready) begin
            lcd_dcx  <= byte_data.is_data;
            lcd_data <= byte_data.value;
        end
    end

endmodule

`default_nettype wire

// File: mmio_regs.sv
`timescale 1ns/100ps
`include "kbd_lcd_params.svh"
`default_nettype none

module mmio_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [3:0]             wb_adr,
    input  logic [31:0]            wb_dat_w,
    output logic [31:0]            wb_dat_r,
    output logic                   wb_ack,
    input  logic                   key_valid,
    input  kbd_lcd_pkg::key_code_t key_code,
    output logic                   key_pop,
    output logic                   lcd_push_valid,
    input  logic                   lcd_push_ready,
    output kbd_lcd_pkg::lcd_byte_t lcd_push_data,
    input  logic                   lcd_idle,
    input  logic                   lcd_empty
);

    kbd_lcd_pkg::reg_index_t reg_idx;
    logic                    req;
    logic                    is_key;
    logic                    is_status;
    logic                    is_lcd;
    logic                    ack_next;
    logic [31:0]             rd_value;

    assign reg_idx   = kbd_lcd_pkg::reg_index_t'(wb_adr[3:2]);
    assign is_key    = (reg_idx == kbd_lcd_pkg::reg_index_t'(`KL_REG_KEY));
    assign is_status = (reg_idx == kbd_lcd_pkg::reg_index_t'(`KL_REG_STATUS));
    assign is_lcd    = (reg_idx == kbd_lcd_pkg::reg_index_t'(`KL_REG_LCD_CMD)) ||
                       (reg_idx == kbd_lcd_pkg::reg_index_t'(`KL_REG_LCD_DATA));

    // New request only when not already acking, keeps ack to one cycle
    assign req = wb_cyc && wb_stb && !wb_ack;

    // LCD writes wait for room in the queue
    assign ack_next = req && !(wb_we && is_lcd && !lcd_push_ready);

    // Side effects happen in the ack cycle, master still holds the request
    // Key pop only when the returned word carried a valid event
    assign key_pop        = wb_ack && !wb_we && is_key && wb_dat_r[8];
    assign lcd_push_valid = wb_ack && wb_we && is_lcd;

    always_comb begin
        lcd_push_data.is_data = (reg_idx == kbd_lcd_pkg::reg_index_t'(`KL_REG_LCD_DATA));
        lcd_push_data.value   = wb_dat_w[7:0];
    end

    always_comb begin
        rd_value = 32'h0;
        if (is_key && key_valid) begin
            rd_value[8]   = 1'b1;
            rd_value[3:0] = key_code;
        end else if (is_status) begin
            rd_value[0] = key_valid;
            rd_value[1] = lcd_empty && lcd_idle;
            rd_value[2] = !lcd_push_ready;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= ack_next;
        end
    end

    // Read data captured together with the decision to ack
    always_ff @(posedge clk) begin
        if (ack_next) begin
            wb_dat_r <= wb_we ? 32'h0 : rd_value;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the keypad/LCD testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_kbd_lcd \
    -f verilog.f -o sim_kbd_lcd > build.log 2>&1 || { cat build.log; exit 1; }

# Simulation status alone is not trusted, the log decides
./obj_dir/sim_kbd_lcd > sim.log 2>&1
cat sim.log
grep -qx "Test OK" sim.log && exit 0 || exit 1

// File: scan_timer.sv
`timescale 1ns/100ps
`include "kbd_lcd_params.svh"
`default_nettype none

module scan_timer (
    input  logic       clk,
    input  logic       rst,
    output logic [3:0] column,
    output logic       scan_pulse,
    output logic [1:0] column_index
);

    localparam int CNT_W = ($clog2(`KL_SCAN_DWELL) > 0) ? $clog2(`KL_SCAN_DWELL) : 1;
    localparam logic [CNT_W-1:0] DWELL_LAST = CNT_W'(`KL_SCAN_DWELL - 1);

    logic [CNT_W-1:0] dwell_cnt;

    // Last cycle of the dwell, rows get sampled here
    assign scan_pulse = (dwell_cnt == DWELL_LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dwell_cnt    <= '0;
            column       <= 4'b0001;
            column_index <= 2'd0;
        end else begin
            if (scan_pulse) begin
                dwell_cnt    <= '0;
                // Rotate one-hot column, index follows along
                column       <= {column[2:0], column[3]};
                column_index <= column_index + 2'd1;
            end else begin
                dwell_cnt <= dwell_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_kbd_lcd.sv
`timescale 1ns/100ps
`include "kbd_lcd_params.svh"
`default_nettype none

module tb_kbd_lcd;

    localparam int SWEEP = 4 * `KL_SCAN_DWELL;
    localparam logic [3:0] ADR_KEY = 4'(`KL_REG_KEY * 4);
    localparam logic [3:0] ADR_STATUS = 4'(`KL_REG_STATUS * 4);
    localparam logic [3:0] ADR_CMD = 4'(`KL_REG_LCD_CMD * 4);
    localparam logic [3:0] ADR_DATA = 4'(`KL_REG_LCD_DATA * 4);

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic [3:0]  row;
    logic [3:0]  column;
    logic        lcd_csx;
    logic        lcd_wrx;
    logic        lcd_dcx;
    logic [7:0]  lcd_data;

    logic [15:0] keys_down;
    logic [8:0]  lcd_expected [$];
    string       test_name;
    int          error_count;
    int          test_errors_start;
    int          tests_run;
    int          tests_failed;
    int          seed;

    kbd_lcd_top kbd_lcd_top_i (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .row      (row),
        .column   (column),
        .lcd_csx  (lcd_csx),
        .lcd_wrx  (lcd_wrx),
        .lcd_dcx  (lcd_dcx),
        .lcd_data (lcd_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Keypad matrix, the active column sees the rows of its held keys
    always @(negedge clk) begin
        row = 4'b0000;
        for (int c = 0; c < 4; c++) begin
            if (column[c]) begin
                row = keys_down[c*4 +: 4];
            end
        end
    end

    // Display latches on the rising write strobe
    always @(posedge lcd_wrx) begin
        if (!rst) begin
            check_lcd_byte({lcd_dcx, lcd_data});
        end
    end

    function automatic logic [15:0] key_mask(input int col, input int row_index);
        return 16'(1) << (col * 4 + row_index);
    endfunction

    // KEY register image for a valid event
    function automatic logic [31:0] key_read_value(input int col, input int row_index);
        return 32'h100 | 32'(col * 4 + row_index);
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error %s %s: expected %h actual %h", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_lcd_byte(input logic [8:0] actual);
        logic [8:0] expected;
        assert (lcd_expected.size() != 0) else begin
            $display("%s: LCD byte %h was written while none was queued", test_name, actual);
            error_count++;
        end
        if (lcd_expected.size() != 0) begin
            expected = lcd_expected.pop_front();
            check_value("lcd byte", 32'(expected), 32'(actual));
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s: %s", test_name, reason);
        $display("Test FAILED");
        $finish;
    endtask

    // Request held through the ack cycle, released at the following falling edge
    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] data,
                             output logic [31:0] rdata);
        int waited;
        waited = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        @(negedge clk);
        while (!wb_ack) begin
            waited++;
            if (waited > 200) begin
                abort_run("no Wishbone ack within 200 cycles");
            end
            @(negedge clk);
        end
        rdata = wb_dat_r;
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
        logic [31:0] unused_rdata;
        if (adr == ADR_CMD) begin
            lcd_expected.push_back({1'b0, data[7:0]});
        end else if (adr == ADR_DATA) begin
            lcd_expected.push_back({1'b1, data[7:0]});
        end
        wb_access(1'b1, adr, data, unused_rdata);
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] rdata);
        wb_access(1'b0, adr, 32'h0, rdata);
    endtask

    task automatic wait_status(input int bit_index, input logic value, input int limit);
        logic [31:0] status;
        int          tries;
        tries = 0;
        wb_read(ADR_STATUS, status);
        while (status[bit_index] !== value) begin
            tries++;
            if (tries > limit) begin
                abort_run($sformatf("STATUS bit %0d never became %0b", bit_index, value));
            end
            wb_read(ADR_STATUS, status);
        end
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_errors_start = error_count;
    endtask

    task automatic finish_test();
        tests_run++;
        if (error_count == test_errors_start) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed, %0d errors", test_name, error_count - test_errors_start);
        end
    endtask

    task automatic release_keys();
        keys_down = 16'h0;
        // Partial sweep plus one full empty sweep re-arms the decoder
        repeat (3 * SWEEP) @(negedge clk);
    endtask

    initial begin
        logic [31:0] rdata;
        logic [7:0]  value;
        logic        saw_full;
        seed              = 32'h9108_bc37;
        rst               = 1'b1;
        wb_cyc            = 1'b0;
        wb_stb            = 1'b0;
        wb_we             = 1'b0;
        wb_adr            = 4'h0;
        wb_dat_w          = 32'h0;
        row               = 4'h0;
        keys_down         = 16'h0;
        error_count       = 0;
        test_errors_start = 0;
        tests_run         = 0;
        tests_failed      = 0;
        test_name         = "reset";
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        start_test("reset_state");
        check_value("lcd_csx", 32'h1, 32'(lcd_csx));
        check_value("lcd_wrx", 32'h1, 32'(lcd_wrx));
        check_value("column", 32'h1, 32'(column));
        wb_read(ADR_STATUS, rdata);
        check_value("status", 32'h2, rdata);
        finish_test();

        start_test("lcd_cmd_data");
        wb_write(ADR_CMD, 32'h2c);
        wb_write(ADR_DATA, 32'ha5);
        wait_status(1, 1'b1, 100);
        check_value("bytes not shown", 32'h0, 32'(lcd_expected.size()));
        finish_test();

        start_test("lcd_burst");
        saw_full = 1'b0;
        for (int i = 0; i < 10; i++) begin
            value = 8'($random(seed));
            wb_write(ADR_DATA, {24'h0, value});
            // Queue fills after six back-to-back writes
            if (i >= 5) begin
                wb_read(ADR_STATUS, rdata);
                saw_full = saw_full | rdata[2];
            end
        end
        wait_status(1, 1'b1, 200);
        check_value("bytes not shown", 32'h0, 32'(lcd_expected.size()));
        check_value("full seen", 32'h1, 32'(saw_full));
        finish_test();

        start_test("key_press");
        keys_down = key_mask(2, 1);
        wait_status(0, 1'b1, 300);
        wb_read(ADR_KEY, rdata);
        check_value("first key read", key_read_value(2, 1), rdata);
        wb_read(ADR_KEY, rdata);
        check_value("second key read", 32'h0, rdata);
        finish_test();

        start_test("release_repress");
        release_keys();
        keys_down = key_mask(0, 3);
        wait_status(0, 1'b1, 300);
        wb_read(ADR_KEY, rdata);
        check_value("key read", key_read_value(0, 3), rdata);
        repeat (3 * SWEEP) @(negedge clk);
        wb_read(ADR_STATUS, rdata);
        check_value("extra event", 32'h0, 32'(rdata[0]));
        finish_test();

        start_test("two_keys");
        release_keys();
        keys_down = key_mask(3, 0) | key_mask(1, 2);
        wait_status(0, 1'b1, 300);
        wb_read(ADR_KEY, rdata);
        check_value("key read", key_read_value(1, 2), rdata);
        keys_down = 16'h0;
        finish_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
kbd_lcd_pkg.sv
scan_timer.sv
keypad_decoder.sv
event_queue.sv
lcd_write_fsm.sv
mmio_regs.sv
kbd_lcd_top.sv
kbd_lcd_assert.sv
tb_kbd_lcd.sv
